//--- hdl/mci_pkg.sv
package mci_pkg;

	// memory bus carries one whole cache block per transfer
	localparam int MCI_DATA_LENGTH = 128;

	// cache to memory command
	typedef struct packed {
		// one-cycle command strobe
		logic valid;
		// 1 for a block write, 0 for a block read
		logic rw;
		// block address
		// offset bits are zero on write-backs
		logic [31:0] addr;
		// block being written back
		logic [MCI_DATA_LENGTH-1:0] data;
	} mci_request_t;

	// memory to cache completion
	typedef struct packed {
		// one pulse per command once it has completed
		logic ready;
		// block read from memory, valid with ready
		logic [MCI_DATA_LENGTH-1:0] data;
	} mci_response_t;

endpackage

//--- hdl/dcache_pkg.sv
package dcache_pkg;

	// word and address widths of the cpu port
	localparam int DATA_LENGTH = 32;
	localparam int ADDR_LENGTH = 32;

	// words per block, one block per memory bus transfer
	localparam int BLOCK_SIZE = 4;
	// number of lines, kept small so random traffic evicts
	localparam int BLOCK_COUNT = 16;

	// address field widths
	localparam int OFFSET_BITS = $clog2(DATA_LENGTH / 8 * BLOCK_SIZE);
	localparam int INDEX_BITS = $clog2(BLOCK_COUNT);
	localparam int TAG_BITS = ADDR_LENGTH - INDEX_BITS - OFFSET_BITS;

	// address field bounds, offset at the bottom and tag at the top
	localparam int OFFSET_LSB = 0;
	localparam int OFFSET_MSB = OFFSET_LSB + OFFSET_BITS - 1;
	localparam int INDEX_LSB = OFFSET_MSB + 1;
	localparam int INDEX_MSB = INDEX_LSB + INDEX_BITS - 1;
	localparam int TAG_LSB = INDEX_MSB + 1;
	localparam int TAG_MSB = TAG_LSB + TAG_BITS - 1;

	// word select inside a block, just above the byte offset
	localparam int WORD_LSB = 2;
	localparam int WORD_MSB = WORD_LSB + $clog2(BLOCK_SIZE) - 1;

	// load/store request from the cpu
	typedef struct packed {
		logic valid;
		// 1 means store
		logic rw;
		logic [ADDR_LENGTH-1:0] addr;
		logic [DATA_LENGTH-1:0] wdata;
		// bit-level write mask
		logic [DATA_LENGTH-1:0] wmask;
	} cpu_req_t;

	// per-line bookkeeping
	typedef struct packed {
		logic valid;
		logic dirty;
		logic [TAG_BITS-1:0] tag;
	} cache_tag_t;

	// controller FSM states
	typedef enum logic [1:0] {
		IDLE,
		COMPARE,
		ALLOCATE,
		WRITE_BACK
	} dcache_state_t;

endpackage

//--- hdl/cache_word_bank.sv
`timescale 1ns/1ns

module cache_word_bank import dcache_pkg::*; (
	input logic clk,
	input logic [INDEX_BITS-1:0] index,
	input logic we,
	input logic [DATA_LENGTH-1:0] wdata,
	output logic [DATA_LENGTH-1:0] rdata
);

	// one word of every line, for this word position
	logic [DATA_LENGTH-1:0] mem [BLOCK_COUNT];

	// read is combinational so the controller sees the word in the same cycle
	assign rdata = mem[index];

	// write lands on the clock edge
	always_ff @(posedge clk) begin
		if (we) begin
			mem[index] <= wdata;
		end
	end

	// an unknown enable would corrupt a line silently
	// the controller must hold it known from the first edge on
	we_known_a: assert property (@(posedge clk) !$isunknown(we))
		else $error("cache_word_bank: write enable is unknown");

endmodule

//--- hdl/cache_tag_array.sv
`timescale 1ns/1ns

module cache_tag_array import dcache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [INDEX_BITS-1:0] index,
	input logic we,
	input cache_tag_t wdata,
	output cache_tag_t rdata
);

	// one tag entry per line
	cache_tag_t mem [BLOCK_COUNT];

	// combinational read for the hit compare
	assign rdata = mem[index];

	always_ff @(posedge clk) begin
		if (rst) begin
			// all lines invalid and clean
			for (int i = 0; i < BLOCK_COUNT; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[index] <= wdata;
		end
	end

	// an entry written last cycle must not end up dirty and invalid
	// otherwise a later miss would write back garbage
	dirty_valid_a: assert property (
		@(posedge clk) disable iff (rst)
		we |=> !(mem[$past(index)].dirty && !mem[$past(index)].valid)
	) else $error("cache_tag_array: entry stored dirty while invalid");

endmodule

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl import mci_pkg::*, dcache_pkg::*; (
	input logic clk,
	input logic rst,
	// cpu side
	input cpu_req_t cpu_req,
	output logic ready,
	output logic rvalid,
	output logic [DATA_LENGTH-1:0] rdata,
	// memory side
	output mci_request_t mem_req,
	input mci_response_t mem_res,
	// tag array
	output logic [INDEX_BITS-1:0] tag_index,
	output logic tag_we,
	output cache_tag_t tag_wdata,
	input cache_tag_t tag_rdata,
	// word banks
	output logic [INDEX_BITS-1:0] bank_index,
	output logic [BLOCK_SIZE-1:0] bank_we,
	output logic [MCI_DATA_LENGTH-1:0] bank_wdata,
	input logic [MCI_DATA_LENGTH-1:0] bank_rdata
);

	dcache_state_t state;
	dcache_state_t state_nxt;

	// request fields held for the whole access
	logic [ADDR_LENGTH-1:0] addr_q;
	logic rw_q;
	logic [DATA_LENGTH-1:0] wdata_q;
	logic [DATA_LENGTH-1:0] wmask_q;

	logic [INDEX_BITS-1:0] index;
	logic [WORD_MSB-WORD_LSB:0] word_sel;
	logic [DATA_LENGTH-1:0] old_word;
	logic [DATA_LENGTH-1:0] merged_word;
	logic hit;
	logic [ADDR_LENGTH-1:0] fill_addr;
	logic [ADDR_LENGTH-1:0] evict_addr;

	// arrays see the incoming address while idle
	// after acceptance they follow the latched one
	assign index = (state == IDLE) ? cpu_req.addr[INDEX_MSB:INDEX_LSB]
		: addr_q[INDEX_MSB:INDEX_LSB];
	assign tag_index = index;
	assign bank_index = index;

	// addressed word out of the block
	assign word_sel = addr_q[WORD_MSB:WORD_LSB];
	assign old_word = bank_rdata[word_sel*DATA_LENGTH +: DATA_LENGTH];

	// masked bits come from the store data, the rest stays
	assign merged_word = (old_word & ~wmask_q) | (wdata_q & wmask_q);

	// cpu gets the word as it was before this access wrote it
	assign rdata = old_word;

	assign hit = tag_rdata.valid && (tag_rdata.tag == addr_q[TAG_MSB:TAG_LSB]);

	// block addresses with the offset cleared
	assign fill_addr = {addr_q[TAG_MSB:INDEX_LSB], {OFFSET_BITS{1'b0}}};
	// victim block sits at the old tag with the same index
	assign evict_addr = {tag_rdata.tag, addr_q[INDEX_MSB:INDEX_LSB], {OFFSET_BITS{1'b0}}};

	// new requests only while idle
	assign ready = (state == IDLE);

	always_comb begin
		state_nxt = state;
		rvalid = 1'b0;
		tag_we = 1'b0;
		tag_wdata = '0;
		bank_we = '0;
		// every word carries the merge, bank_we picks the one that lands
		bank_wdata = {BLOCK_SIZE{merged_word}};
		mem_req.valid = 1'b0;
		mem_req.rw = 1'b0;
		mem_req.addr = fill_addr;
		// write-back data is the line currently held at this index
		mem_req.data = bank_rdata;

		case (state)
			IDLE: begin
				if (cpu_req.valid) begin
					state_nxt = COMPARE;
				end
			end

			COMPARE: begin
				if (hit) begin
					// access completes this cycle
					rvalid = 1'b1;
					if (rw_q) begin
						// store touches only the addressed word
						bank_we[word_sel] = 1'b1;
						tag_we = 1'b1;
						tag_wdata = '{valid: 1'b1, dirty: 1'b1, tag: tag_rdata.tag};
					end
					state_nxt = IDLE;
				end else begin
					// line now belongs to the new block
					tag_we = 1'b1;
					tag_wdata = '{valid: 1'b1, dirty: rw_q, tag: addr_q[TAG_MSB:TAG_LSB]};
					mem_req.valid = 1'b1;
					if (tag_rdata.valid && tag_rdata.dirty) begin
						// old block goes out first
						mem_req.rw = 1'b1;
						mem_req.addr = evict_addr;
						state_nxt = WRITE_BACK;
					end else begin
						// clean or empty line, fetch straight away
						state_nxt = ALLOCATE;
					end
				end
			end

			ALLOCATE: begin
				// wait for the block and fill the whole line
				if (mem_res.ready) begin
					bank_we = '1;
					bank_wdata = mem_res.data;
					// compare again, which now hits
					state_nxt = COMPARE;
				end
			end

			WRITE_BACK: begin
				// write-back done, now ask for the new block
				if (mem_res.ready) begin
					mem_req.valid = 1'b1;
					state_nxt = ALLOCATE;
				end
			end

			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// capture the request on acceptance
	always_ff @(posedge clk) begin
		if (cpu_req.valid && ready) begin
			addr_q <= cpu_req.addr;
			rw_q <= cpu_req.rw;
			wdata_q <= cpu_req.wdata;
			wmask_q <= cpu_req.wmask;
		end
	end

	// completion only from compare, and the cache is free on the next cycle
	rvalid_compare_a: assert property (
		@(posedge clk) disable iff (rst)
		rvalid |-> (state == COMPARE) ##1 ready
	) else $error("dcache_ctrl: rvalid outside COMPARE or no return to idle");

	// after a read command no new command until the fill arrives
	fill_outstanding_a: assert property (
		@(posedge clk) disable iff (rst)
		(mem_req.valid && !mem_req.rw) |=> (state == ALLOCATE && !mem_req.valid) until mem_res.ready
	) else $error("dcache_ctrl: memory command issued during an outstanding fill");

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ns

module dcache_top import mci_pkg::*, dcache_pkg::*; (
	input logic clk,
	input logic rst,
	// cpu side
	input cpu_req_t cpu_req,
	output logic ready,
	output logic rvalid,
	output logic [DATA_LENGTH-1:0] rdata,
	// memory controller side
	output mci_request_t mem_req,
	input mci_response_t mem_res
);

	// tag array port
	logic [INDEX_BITS-1:0] tag_index;
	logic tag_we;
	cache_tag_t tag_wdata;
	cache_tag_t tag_rdata;

	// block-wide data buses, one word slice per bank
	logic [INDEX_BITS-1:0] bank_index;
	logic [BLOCK_SIZE-1:0] bank_we;
	logic [MCI_DATA_LENGTH-1:0] bank_wdata;
	logic [MCI_DATA_LENGTH-1:0] bank_rdata;

	dcache_ctrl ctrl_inst (
		.clk(clk),
		.rst(rst),
		.cpu_req(cpu_req),
		.ready(ready),
		.rvalid(rvalid),
		.rdata(rdata),
		.mem_req(mem_req),
		.mem_res(mem_res),
		.tag_index(tag_index),
		.tag_we(tag_we),
		.tag_wdata(tag_wdata),
		.tag_rdata(tag_rdata),
		.bank_index(bank_index),
		.bank_we(bank_we),
		.bank_wdata(bank_wdata),
		.bank_rdata(bank_rdata)
	);

	cache_tag_array tag_inst (
		.clk(clk),
		.rst(rst),
		.index(tag_index),
		.we(tag_we),
		.wdata(tag_wdata),
		.rdata(tag_rdata)
	);

	// bank i holds word i of every block
	for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_bank
		cache_word_bank bank_inst (
			.clk(clk),
			.index(bank_index),
			.we(bank_we[i]),
			.wdata(bank_wdata[i*DATA_LENGTH +: DATA_LENGTH]),
			.rdata(bank_rdata[i*DATA_LENGTH +: DATA_LENGTH])
		);
	end

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model import mci_pkg::*; (
	input logic clk,
	input mci_request_t mem_req,
	output mci_response_t mem_res
);

	// blocks that were written back, keyed by block address
	logic [MCI_DATA_LENGTH-1:0] blocks [logic [31:0]];
	// write-back log, read by the testbench
	logic [31:0] wb_addr [$];
	logic [MCI_DATA_LENGTH-1:0] wb_data [$];
	int read_count = 0;
	int write_count = 0;
	// one outstanding command and the cycles it still needs
	mci_request_t cmd;
	logic busy = 1'b0;
	int wait_left = 0;
	logic [31:0] lfsr = 32'hcfc5_b124;

	// unwritten memory, every address bit shows up in the word
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1);
	endfunction

	// word as memory holds it right now
	function automatic logic [31:0] read_word(input logic [31:0] addr);
		logic [MCI_DATA_LENGTH-1:0] blk;
		if (!blocks.exists({addr[31:4], 4'h0})) begin
			return fill_word({addr[31:2], 2'b00});
		end
		blk = blocks[{addr[31:4], 4'h0}];
		return blk[addr[3:2]*32 +: 32];
	endfunction

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// commands are taken at the rising edge like any flop in the cache
	always @(posedge clk) begin
		if (mem_req.valid) begin
			cmd = mem_req;
			busy = 1'b1;
			// 1 to 6 cycles until the ready pulse
			wait_left = 1 + next_bits(3) % 6;
			if (mem_req.rw) begin
				write_count++;
				wb_addr.push_back(mem_req.addr);
				wb_data.push_back(mem_req.data);
			end else begin
				read_count++;
			end
		end
	end

	initial mem_res = '0;

	// completion pulse goes out on the falling edge
	always @(negedge clk) begin
		mem_res.ready = 1'b0;
		if (busy) begin
			wait_left--;
			if (wait_left == 0) begin
				busy = 1'b0;
				mem_res.ready = 1'b1;
				if (cmd.rw) begin
					blocks[{cmd.addr[31:4], 4'h0}] = cmd.data;
				end else begin
					for (int i = 0; i < 4; i++) begin
						mem_res.data[i*32 +: 32] = read_word({cmd.addr[31:4], 4'h0} + 4 * i);
					end
				end
			end
		end
	end

endmodule

//--- testbench/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb import mci_pkg::*, dcache_pkg::*; ();

	logic clk;
	logic rst;
	cpu_req_t cpu_req;
	logic ready;
	logic rvalid;
	logic [DATA_LENGTH-1:0] rdata;
	mci_request_t mem_req;
	mci_response_t mem_res;

	// words the cpu has stored
	// any other word still reads as the fill pattern
	logic [31:0] ref_mem [logic [31:0]];
	logic [31:0] lfsr = 32'hcfc5_b124;
	int errors = 0;
	int checks = 0;
	// write-backs already compared
	int wb_seen = 0;
	// command counts at the last command check
	int read_mark = 0;
	int write_mark = 0;
	// cycles from acceptance to rvalid of the last access
	int last_lat;
	// last address accessed at each index, whose block that line now holds
	logic [31:0] line_addr [BLOCK_COUNT];

	dcache_top dcache_top_inst (.*);

	tb_mem_model mem_model (
		.clk(clk),
		.mem_req(mem_req),
		.mem_res(mem_res)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : mem_model.fill_word(addr);
	endfunction

	task automatic check(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %0h got %0h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	// commands seen since the previous call
	task automatic check_commands(input int reads, input int writes);
		check("read commands", reads, mem_model.read_count - read_mark);
		check("write commands", writes, mem_model.write_count - write_mark);
		read_mark = mem_model.read_count;
		write_mark = mem_model.write_count;
	endtask

	// a written-back block must match what the cpu last saw there
	task automatic check_writebacks();
		logic [31:0] addr;
		while (wb_seen < mem_model.wb_addr.size()) begin
			addr = mem_model.wb_addr[wb_seen];
			for (int i = 0; i < 4; i++) begin
				check("write-back data", ref_read(addr + 4 * i),
					mem_model.wb_data[wb_seen][i*32 +: 32]);
			end
			wb_seen++;
		end
	endtask

	// one access that starts and ends on a falling edge
	task automatic cpu_op(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [31:0] wmask);
		logic [31:0] expected;
		int n;
		expected = ref_read(addr);
		n = 0;
		while (!ready && n < 64) begin
			@(negedge clk);
			n++;
		end
		if (!ready) begin
			$display("timeout at %0t ns: cache not ready for a new request", $time);
			errors++;
		end
		cpu_req = {1'b1, rw, addr, wdata, wmask};
		@(negedge clk);
		cpu_req.valid = 1'b0;
		// one access in flight, so no new request is taken
		check("ready", 0, ready);
		last_lat = 1;
		while (!rvalid && last_lat < 64) begin
			@(negedge clk);
			last_lat++;
		end
		if (!rvalid) begin
			$display("timeout at %0t ns: no rvalid for address %h", $time, addr);
			errors++;
		end else begin
			// rdata is the word before this access wrote it
			check("rdata", expected, rdata);
			@(negedge clk);
			// free again in the cycle after rvalid
			check("ready", 1, ready);
		end
		check_writebacks();
		if (rw) begin
			ref_mem[addr] = (expected & ~wmask) | (wdata & wmask);
		end
		line_addr[addr[INDEX_MSB:INDEX_LSB]] = addr;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	endtask

	task automatic end_test(input string name, input int mark);
		$display("test %s finished with %0d errors", name, errors - mark);
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] wm;
		logic [31:0] wr;
		int mark;
		clk = 1'b0;
		cpu_req = '0;
		apply_reset();

		// cold miss fetches once and writes nothing
		mark = errors;
		a = 32'h0000_1234;
		cpu_op(1'b0, a, '0, '0);
		check_commands(1, 0);
		end_test("cold_read_miss", mark);

		// same word again answers the cycle after acceptance
		mark = errors;
		cpu_op(1'b0, a, '0, '0);
		check("hit latency", 1, last_lat);
		check_commands(0, 0);
		end_test("hit_timing", mark);

		// masked store and a read back of every word in the block
		mark = errors;
		wd = random_bits(32);
		wm = random_bits(32);
		cpu_op(1'b1, a, wd, wm);
		check("hit latency", 1, last_lat);
		for (int i = 0; i < 4; i++) begin
			cpu_op(1'b0, {a[31:4], 4'h0} + 4 * i, '0, '0);
		end
		check_commands(0, 0);
		end_test("masked_write_hit", mark);

		// next tag up at the same index pushes the dirty block out
		mark = errors;
		cpu_op(1'b0, a + 32'h100, '0, '0);
		check_commands(1, 1);
		check("write-back address", {a[31:4], 4'h0},
			mem_model.wb_addr[mem_model.wb_addr.size() - 1]);
		cpu_op(1'b0, a, '0, '0);
		check_commands(1, 0);
		end_test("dirty_eviction", mark);

		// 8 tags by 16 lines so evictions are frequent
		mark = errors;
		for (int n = 0; n < 300; n++) begin
			a = 32'h0000_4000;
			a[10:8] = random_bits(3);
			a[7:4] = random_bits(4);
			a[3:2] = random_bits(2);
			wr = random_bits(1);
			wd = random_bits(32);
			wm = random_bits(32);
			cpu_op(wr[0], a, wd, wm);
		end
		end_test("random_mix", mark);

		mark = errors;
		apply_reset();
		// dirty words that never reached memory are lost
		foreach (ref_mem[k]) begin
			ref_mem[k] = mem_model.read_word(k);
		end
		read_mark = mem_model.read_count;
		write_mark = mem_model.write_count;
		// each line held a block before the reset, so its first access must fetch
		for (int i = 0; i < BLOCK_COUNT; i++) begin
			cpu_op(1'b0, line_addr[i], '0, '0);
			check_commands(1, 0);
		end
		end_test("reset_clears_tags", mark);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- project.f
hdl/mci_pkg.sv
hdl/dcache_pkg.sv
hdl/cache_word_bank.sv
hdl/cache_tag_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/tb_mem_model.sv
testbench/dcache_tb.sv
